// ==== rv32i_ooo_alu.f ====
+incdir+source
source/rv32i_alu_pkg.sv
source/issue_decode.sv
source/reservation_station.sv
source/alu_execute.sv
source/result_table.sv
source/rv32i_alu_core.sv
testbench/tb_clock_gen.sv
testbench/rv32i_alu_core_properties.sv
testbench/rv32i_alu_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run with Verilator, verdict taken from the log
cd "$(dirname "$0")" &&
(verilator --binary --timing --assert --top-module rv32i_alu_core_tb \
	-f rv32i_ooo_alu.f -o sim_tb && ./obj_dir/sim_tb) > sim.log 2>&1
grep -q "^=== PASS ===$" sim.log && echo "simulation passed" ||
	{ echo "simulation failed, see sim.log"; exit 1; }

// ==== testbench/rv32i_alu_core_tb.sv ====
`timescale 1ns/1ps
`include "rv32i_alu_defs.svh"

module rv32i_alu_core_tb;

	localparam int n_tags = 1 << `TAG_W;
	// instruction budget over all phases
	localparam int n_budget = 600;
	localparam int limit_cycles = n_budget * 40;

	logic clk;
	logic arst_n;
	logic flush;
	logic issue;
	rv32i_alu_pkg::pci_t pci;
	rv32i_alu_pkg::src_t src;
	rv32i_alu_pkg::tag_t issue_tag;
	rv32i_alu_pkg::result_t result;
	rv32i_alu_pkg::rs_count_t num_available;

	// values applied at the next rising edge
	logic nx_issue;
	logic nx_flush;
	rv32i_alu_pkg::pci_t nx_pci;
	rv32i_alu_pkg::src_t nx_src;
	rv32i_alu_pkg::tag_t nx_tag;

	// reference model with one slot per tag
	logic inflight [n_tags];
	logic stored [n_tags];
	rv32i_alu_pkg::word_t exp_val [n_tags];
	int refcnt [n_tags];
	logic has_p1 [n_tags];
	logic has_p2 [n_tags];
	rv32i_alu_pkg::tag_t p1 [n_tags];
	rv32i_alu_pkg::tag_t p2 [n_tags];

	logic [31:0] rng;

	tb_clock_gen u_clk (
		.clk(clk),
		.arst_n(arst_n)
	);

	rv32i_alu_core u_dut (
		.clk(clk),
		.arst_n(arst_n),
		.flush(flush),
		.issue(issue),
		.pci(pci),
		.src(src),
		.issue_tag(issue_tag),
		.result(result),
		.num_available(num_available)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] rand32();
		rng = xorshift32(rng);
		return rng;
	endfunction

	task automatic print_fail_and_stop();
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped");
	endtask

	task automatic fail_run(input string what);
		$display("error at %0t: %s", $time, what);
		print_fail_and_stop();
	endtask

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
		begin
			$display("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
			print_fail_and_stop();
		end
	endtask

	// branch condition per funct3
	function automatic logic branch_taken(input logic [2:0] f3,
		input rv32i_alu_pkg::word_t a, input rv32i_alu_pkg::word_t b);
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			default: return a >= b;
		endcase
	endfunction

	// architectural result of one instruction
	function automatic rv32i_alu_pkg::word_t expected_value(input rv32i_alu_pkg::pci_t p,
		input rv32i_alu_pkg::word_t a, input rv32i_alu_pkg::word_t b);
		rv32i_alu_pkg::word_t rhs;
		logic [4:0] sh;
		rhs = (p.opcode == rv32i_alu_pkg::op_reg) ? b : p.i_imm;
		sh = rhs[4:0];
		case (p.opcode)
			rv32i_alu_pkg::op_lui: return p.u_imm;
			rv32i_alu_pkg::op_auipc: return p.pc + p.u_imm;
			rv32i_alu_pkg::op_jal: return p.pc + p.j_imm;
			rv32i_alu_pkg::op_jalr: return a + p.i_imm;
			rv32i_alu_pkg::op_br: return rv32i_alu_pkg::word_t'(branch_taken(p.funct3, a, b));
			default:
			begin
				case (p.funct3)
					// sub exists only for register ops
					3'b000: return (p.opcode == rv32i_alu_pkg::op_reg && p.funct7_b5) ?
						a - rhs : a + rhs;
					3'b001: return a << sh;
					3'b010: return rv32i_alu_pkg::word_t'($signed(a) < $signed(rhs));
					3'b011: return rv32i_alu_pkg::word_t'(a < rhs);
					3'b100: return a ^ rhs;
					3'b101: return p.funct7_b5 ?
						rv32i_alu_pkg::word_t'($signed(a) >>> sh) : a >> sh;
					3'b110: return a | rhs;
					default: return a & rhs;
				endcase
			end
		endcase
	endfunction

	// value or busy reference toward a known producer
	task automatic pick_operand(input int dep_pct, input int cands[$],
		output rv32i_alu_pkg::word_t val, output logic busy,
		output rv32i_alu_pkg::word_t known, output rv32i_alu_pkg::tag_t dep);
		logic [31:0] r;
		r = rand32();
		dep = '0;
		if (cands.size() > 0 && int'(rand32() % 100) < dep_pct)
		begin
			dep = rv32i_alu_pkg::tag_t'(cands[rand32() % cands.size()]);
			val = {r[31:`TAG_W], dep};
			busy = 1'b1;
			known = exp_val[dep];
		end
		else
		begin
			// small values now and then for shifts and compares
			val = (rand32() % 3 == 0) ? (r & 32'h1f) : r;
			busy = 1'b0;
			known = val;
		end
	endtask

	// one random instruction with the model updated at decision time
	task automatic plan_issue(input int dep_pct);
		int free_list[$];
		int cands[$];
		rv32i_alu_pkg::tag_t t_new;
		rv32i_alu_pkg::pci_t p;
		rv32i_alu_pkg::word_t va, vb, ka, kb;
		logic ba, bb, use1, use2;
		rv32i_alu_pkg::tag_t da, db;
		logic [31:0] r;
		nx_issue = 1'b0;
		// pending issue still counts against the free slots
		if (int'(num_available) - int'(issue) <= 0)
			return;
		if (rand32() % 4 == 0)
			return;
		for (int t = 0; t < n_tags; t++)
			if (!inflight[t] && refcnt[t] == 0)
				free_list.push_back(t);
		if (free_list.size() == 0)
			return;
		t_new = rv32i_alu_pkg::tag_t'(free_list[rand32() % free_list.size()]);
		for (int t = 0; t < n_tags; t++)
			if ((inflight[t] || stored[t]) && rv32i_alu_pkg::tag_t'(t) != t_new)
				cands.push_back(t);

		case (rand32() % 7)
			0: p.opcode = rv32i_alu_pkg::op_lui;
			1: p.opcode = rv32i_alu_pkg::op_auipc;
			2: p.opcode = rv32i_alu_pkg::op_jal;
			3: p.opcode = rv32i_alu_pkg::op_jalr;
			4: p.opcode = rv32i_alu_pkg::op_br;
			5: p.opcode = rv32i_alu_pkg::op_imm;
			default: p.opcode = rv32i_alu_pkg::op_reg;
		endcase
		r = rand32();
		p.funct3 = r[2:0];
		p.funct7_b5 = r[3];
		// 010 and 011 are no branch conditions
		if (p.opcode == rv32i_alu_pkg::op_br && p.funct3[2:1] == 2'b01)
			p.funct3[2] = 1'b1;
		r = rand32();
		p.pc = {r[31:2], 2'b00};
		r = rand32();
		p.i_imm = {{20{r[11]}}, r[11:0]};
		p.u_imm = {r[31:12], 12'h000};
		r = rand32();
		p.j_imm = {{11{r[20]}}, r[20:1], 1'b0};

		use1 = p.opcode inside {rv32i_alu_pkg::op_jalr, rv32i_alu_pkg::op_br,
			rv32i_alu_pkg::op_imm, rv32i_alu_pkg::op_reg};
		use2 = p.opcode inside {rv32i_alu_pkg::op_br, rv32i_alu_pkg::op_reg};
		pick_operand(use1 ? dep_pct : 0, cands, va, ba, ka, da);
		pick_operand(use2 ? dep_pct : 0, cands, vb, bb, kb, db);
		// equal operands for beq and bge edges
		if (!ba && !bb && rand32() % 4 == 0)
		begin
			vb = va;
			kb = ka;
		end

		inflight[t_new] = 1'b1;
		stored[t_new] = 1'b0;
		exp_val[t_new] = expected_value(p, ka, kb);
		has_p1[t_new] = use1 && ba;
		has_p2[t_new] = use2 && bb;
		p1[t_new] = da;
		p2[t_new] = db;
		if (use1 && ba)
			refcnt[da]++;
		if (use2 && bb)
			refcnt[db]++;

		nx_issue = 1'b1;
		nx_tag = t_new;
		nx_pci = p;
		nx_src = '{r1: va, busy_r1: ba, r2: vb, busy_r2: bb};
	endtask

	// broadcast check against the model
	task automatic observe();
		rv32i_alu_pkg::tag_t t;
		if (result.valid === 1'b1)
		begin
			t = result.tag;
			if (!inflight[t])
				fail_run($sformatf("tag %0d was broadcast but is not in flight", t));
			check_eq(result.data, exp_val[t], $sformatf("result of tag %0d", t));
			inflight[t] = 1'b0;
			stored[t] = 1'b1;
			if (has_p1[t])
				refcnt[p1[t]]--;
			if (has_p2[t])
				refcnt[p2[t]]--;
		end
	endtask

	task automatic step();
		@(posedge clk);
		issue <= nx_issue;
		flush <= nx_flush;
		pci <= nx_pci;
		src <= nx_src;
		issue_tag <= nx_tag;
		@(negedge clk);
		observe();
	endtask

	function automatic logic any_inflight();
		for (int t = 0; t < n_tags; t++)
			if (inflight[t])
				return 1'b1;
		return 1'b0;
	endfunction

	task automatic model_clear();
		for (int t = 0; t < n_tags; t++)
		begin
			inflight[t] = 1'b0;
			stored[t] = 1'b0;
			refcnt[t] = 0;
			has_p1[t] = 1'b0;
			has_p2[t] = 1'b0;
		end
	endtask

	task automatic run_random(input int cycles, input int dep_pct);
		repeat (cycles)
		begin
			plan_issue(dep_pct);
			step();
		end
	endtask

	// idle until every tracked tag has broadcast
	task automatic drain();
		nx_issue = 1'b0;
		while (any_inflight())
			step();
	endtask

	task automatic do_flush();
		nx_issue = 1'b0;
		nx_flush = 1'b1;
		step();
		nx_flush = 1'b0;
		step();
		model_clear();
		check_eq(32'(num_available), 32'(`RS_SIZE), "free entries after flush");
		check_eq(32'(result.valid), 32'd0, "broadcast after flush");
	endtask

	// entry waiting on its own tag that never wakes
	task automatic block_slot(input rv32i_alu_pkg::tag_t t);
		nx_issue = 1'b1;
		nx_tag = t;
		nx_pci = '0;
		nx_pci.opcode = rv32i_alu_pkg::op_reg;
		nx_src = '{r1: rv32i_alu_pkg::word_t'(t), busy_r1: 1'b1, r2: 32'd5, busy_r2: 1'b0};
		stored[t] = 1'b0;
		step();
	endtask

	// watchdog
	initial
	begin
		repeat (limit_cycles) @(posedge clk);
		fail_run("watchdog expired before the tests completed");
	end

	initial
	begin
		rng = 32'h1a27_3fb3;
		issue = 1'b0;
		flush = 1'b0;
		pci = '0;
		src = '0;
		issue_tag = '0;
		nx_issue = 1'b0;
		nx_flush = 1'b0;
		nx_pci = '0;
		nx_src = '0;
		nx_tag = '0;
		model_clear();
		@(posedge arst_n);
		@(negedge clk);
		check_eq(32'(num_available), 32'(`RS_SIZE), "free entries after reset");

		// independent instructions
		run_random(160, 0);
		drain();
		// dependency chains
		run_random(220, 60);
		drain();
		// consumers of already stored producers
		run_random(12, 100);
		drain();

		// full station and then a dropped issue
		do_flush();
		for (int k = 0; k < n_tags; k++)
			block_slot(rv32i_alu_pkg::tag_t'(k));
		nx_tag = '0;
		nx_pci = '0;
		nx_pci.opcode = rv32i_alu_pkg::op_imm;
		nx_src = '0;
		step();
		check_eq(32'(num_available), 32'd0, "free entries with a full station");
		nx_issue = 1'b0;
		repeat (10)
		begin
			step();
			check_eq(32'(num_available), 32'd0, "full station stays full");
			check_eq(32'(result.valid), 32'd0, "dropped issue broadcast");
		end
		do_flush();

		// flush with entries waiting and more traffic after it
		run_random(40, 50);
		for (int t = 0; t < n_tags; t++)
		begin
			if (!inflight[t] && refcnt[t] == 0 && int'(num_available) - int'(issue) > 0)
			begin
				block_slot(rv32i_alu_pkg::tag_t'(t));
				break;
			end
		end
		do_flush();
		run_random(160, 40);
		drain();
		repeat (5) step();

		$display("=== PASS ===");
		$finish;
	end

endmodule

// ==== testbench/rv32i_alu_core_properties.sv ====
`timescale 1ns/1ps
`include "rv32i_alu_defs.svh"

module rv32i_alu_core_properties
(
	input logic clk,
	input logic arst_n,
	input logic flush,
	input rv32i_alu_pkg::result_t result,
	input rv32i_alu_pkg::rs_count_t num_available
);

	// broadcast strobe always driven
	a_valid_known: assert property (@(posedge clk) disable iff (!arst_n)
		!$isunknown(result.valid))
		else $error("result valid is unknown");

	// free count bounded by station depth
	a_count_range: assert property (@(posedge clk) disable iff (!arst_n)
		num_available <= rv32i_alu_pkg::rs_count_t'(`RS_SIZE))
		else $error("free entry count above station depth");

	// flush empties the station and kills the broadcast
	a_flush_clears: assert property (@(posedge clk) disable iff (!arst_n)
		flush |=> (num_available == rv32i_alu_pkg::rs_count_t'(`RS_SIZE) && !result.valid))
		else $error("station not empty after flush");

endmodule

bind rv32i_alu_core rv32i_alu_core_properties u_props (
	.clk(clk),
	.arst_n(arst_n),
	.flush(flush),
	.result(result),
	.num_available(num_available)
);

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen
(
	output logic clk,
	output logic arst_n
);

	// 20 ns period
	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// reset held for 16 cycles, released away from the rising edge
	initial
	begin
		arst_n = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
	end

endmodule

// ==== source/rv32i_alu_core.sv ====
`timescale 1ns/1ps
`include "rv32i_alu_defs.svh"

module rv32i_alu_core
(
	input logic clk,
	input logic arst_n,
	input logic flush,
	input logic issue,
	input rv32i_alu_pkg::pci_t pci,
	input rv32i_alu_pkg::src_t src,
	input rv32i_alu_pkg::tag_t issue_tag,
	output rv32i_alu_pkg::result_t result,
	output rv32i_alu_pkg::rs_count_t num_available
);

	rv32i_alu_pkg::rs_entry_t new_entry;
	rv32i_alu_pkg::rs_entry_t entries [`RS_SIZE];
	logic [`RS_SIZE-1:0] ready;
	logic exec_take;
	rv32i_alu_pkg::rs_idx_t exec_slot;
	logic [`RS_SIZE-1:0] table_valid;
	rv32i_alu_pkg::word_t table_data [`RS_SIZE];

	// instruction fields to station entry
	issue_decode u_decode (
		.pci(pci),
		.src(src),
		.new_entry(new_entry)
	);

	// waiting entries, gates the issue on free slots
	reservation_station u_station (
		.clk(clk),
		.arst_n(arst_n),
		.flush(flush),
		.issue(issue),
		.issue_tag(issue_tag),
		.new_entry(new_entry),
		.table_valid(table_valid),
		.table_data(table_data),
		.exec_take(exec_take),
		.exec_slot(exec_slot),
		.entries(entries),
		.ready(ready),
		.num_available(num_available)
	);

	// pick, compute, broadcast
	alu_execute u_execute (
		.clk(clk),
		.arst_n(arst_n),
		.flush(flush),
		.entries(entries),
		.ready(ready),
		.exec_take(exec_take),
		.exec_slot(exec_slot),
		.result(result)
	);

	// per tag results for wakeup
	result_table u_table (
		.clk(clk),
		.arst_n(arst_n),
		.flush(flush),
		.result(result),
		.issue(issue),
		.issue_tag(issue_tag),
		.table_valid(table_valid),
		.table_data(table_data)
	);

endmodule

// ==== source/result_table.sv ====
`timescale 1ns/1ps
`include "rv32i_alu_defs.svh"

module result_table
(
	input logic clk,
	input logic arst_n,
	input logic flush,
	input rv32i_alu_pkg::result_t result,
	input logic issue,
	input rv32i_alu_pkg::tag_t issue_tag,
	output logic [`RS_SIZE-1:0] table_valid,
	output rv32i_alu_pkg::word_t table_data [`RS_SIZE]
);

	// stored result per tag
	logic [`RS_SIZE-1:0] valid_q;
	rv32i_alu_pkg::word_t data_q [`RS_SIZE];

	// stored-valid bits
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			valid_q <= '0;
		else if (flush)
			valid_q <= '0;
		else
		begin
			if (result.valid)
				valid_q[result.tag] <= 1'b1;
			// reissued tag forgets its old value
			if (issue)
				valid_q[issue_tag] <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (result.valid)
			data_q[result.tag] <= result.data;
	end

	// live broadcast bypasses the store
	// so a waiting entry captures on the edge after it appears
	always_comb
	begin
		for (int t = 0; t < `RS_SIZE; t++)
		begin
			if (result.valid && result.tag == rv32i_alu_pkg::tag_t'(t))
			begin
				table_valid[t] = 1'b1;
				table_data[t] = result.data;
			end
			else
			begin
				table_valid[t] = valid_q[t];
				table_data[t] = data_q[t];
			end
		end
	end

endmodule

// ==== source/alu_execute.sv ====
`timescale 1ns/1ps
`include "rv32i_alu_defs.svh"

module alu_execute
(
	input logic clk,
	input logic arst_n,
	input logic flush,
	input rv32i_alu_pkg::rs_entry_t entries [`RS_SIZE],
	input logic [`RS_SIZE-1:0] ready,
	output logic exec_take,
	output rv32i_alu_pkg::rs_idx_t exec_slot,
	output rv32i_alu_pkg::result_t result
);

	rv32i_alu_pkg::rs_entry_t sel;
	logic [$clog2(`XLEN)-1:0] shamt;
	rv32i_alu_pkg::word_t alu_out;
	logic cmp_true;
	logic valid_q;
	rv32i_alu_pkg::tag_t tag_q;
	rv32i_alu_pkg::word_t data_q;

	// priority pick, lowest ready slot
	always_comb
	begin
		exec_take = 1'b0;
		exec_slot = '0;
		for (int i = `RS_SIZE - 1; i >= 0; i--)
		begin
			if (ready[i])
			begin
				exec_take = 1'b1;
				exec_slot = rv32i_alu_pkg::rs_idx_t'(i);
			end
		end
	end

	assign sel = entries[exec_slot];
	assign shamt = sel.r2[$clog2(`XLEN)-1:0];

	// add, shift and logic unit
	always_comb
	begin
		case (sel.alu_op)
			rv32i_alu_pkg::alu_add: alu_out = sel.r1 + sel.r2;
			rv32i_alu_pkg::alu_sub: alu_out = sel.r1 - sel.r2;
			rv32i_alu_pkg::alu_sll: alu_out = sel.r1 << shamt;
			rv32i_alu_pkg::alu_srl: alu_out = sel.r1 >> shamt;
			rv32i_alu_pkg::alu_sra: alu_out = rv32i_alu_pkg::word_t'($signed(sel.r1) >>> shamt);
			rv32i_alu_pkg::alu_xor: alu_out = sel.r1 ^ sel.r2;
			rv32i_alu_pkg::alu_or: alu_out = sel.r1 | sel.r2;
			rv32i_alu_pkg::alu_and: alu_out = sel.r1 & sel.r2;
			default: alu_out = sel.r1 + sel.r2;
		endcase
	end

	// comparator, condition as a single bit
	always_comb
	begin
		case (sel.cmp_op)
			rv32i_alu_pkg::cmp_beq: cmp_true = (sel.r1 == sel.r2);
			rv32i_alu_pkg::cmp_bne: cmp_true = (sel.r1 != sel.r2);
			rv32i_alu_pkg::cmp_blt: cmp_true = ($signed(sel.r1) < $signed(sel.r2));
			rv32i_alu_pkg::cmp_bge: cmp_true = ($signed(sel.r1) >= $signed(sel.r2));
			rv32i_alu_pkg::cmp_bltu: cmp_true = (sel.r1 < sel.r2);
			rv32i_alu_pkg::cmp_bgeu: cmp_true = (sel.r1 >= sel.r2);
			default: cmp_true = 1'b0;
		endcase
	end

	// broadcast valid, dropped on flush
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			valid_q <= 1'b0;
		else if (flush)
			valid_q <= 1'b0;
		else
			valid_q <= exec_take;
	end

	// broadcast payload
	always_ff @(posedge clk)
	begin
		tag_q <= sel.tag;
		data_q <= sel.acu_op ? rv32i_alu_pkg::word_t'(cmp_true) : alu_out;
	end

	assign result = '{valid: valid_q, tag: tag_q, data: data_q};

endmodule

// ==== source/reservation_station.sv ====
`timescale 1ns/1ps
`include "rv32i_alu_defs.svh"

module reservation_station
(
	input logic clk,
	input logic arst_n,
	input logic flush,
	input logic issue,
	input rv32i_alu_pkg::tag_t issue_tag,
	input rv32i_alu_pkg::rs_entry_t new_entry,

	// wakeup view, indexed by producer tag
	input logic [`RS_SIZE-1:0] table_valid,
	input rv32i_alu_pkg::word_t table_data [`RS_SIZE],

	// slot consumed by execute this cycle
	input logic exec_take,
	input rv32i_alu_pkg::rs_idx_t exec_slot,

	output rv32i_alu_pkg::rs_entry_t entries [`RS_SIZE],
	output logic [`RS_SIZE-1:0] ready,
	output rv32i_alu_pkg::rs_count_t num_available
);

	// per slot occupancy
	logic [`RS_SIZE-1:0] valid_q;
	// slot contents, meaningful only while valid
	rv32i_alu_pkg::rs_entry_t slot_q [`RS_SIZE];

	logic free_found;
	rv32i_alu_pkg::rs_idx_t free_slot;
	rv32i_alu_pkg::rs_count_t num_free;
	logic accept;

	// lowest free slot
	always_comb
	begin
		free_found = 1'b0;
		free_slot = '0;
		num_free = '0;
		// descending scan so the lowest index wins
		for (int i = `RS_SIZE - 1; i >= 0; i--)
		begin
			if (!valid_q[i])
			begin
				free_found = 1'b1;
				free_slot = rv32i_alu_pkg::rs_idx_t'(i);
				num_free = num_free + rv32i_alu_pkg::rs_count_t'(1);
			end
		end
	end

	// full station or undecodable op drops the issue
	assign accept = issue && free_found && new_entry.valid;
	assign num_available = num_free;

	// occupancy, flush beats issue
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			valid_q <= '0;
		else if (flush)
			valid_q <= '0;
		else
		begin
			// execute only takes valid slots, never the free one
			if (exec_take)
				valid_q[exec_slot] <= 1'b0;
			if (accept)
				valid_q[free_slot] <= 1'b1;
		end
	end

	// payload write and operand capture
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < `RS_SIZE; i++)
		begin
			if (accept && free_slot == rv32i_alu_pkg::rs_idx_t'(i))
			begin
				slot_q[i] <= new_entry;
				slot_q[i].tag <= issue_tag;
			end
			else
			begin
				// busy operand holds its producer tag in the low bits
				if (slot_q[i].busy_r1 && table_valid[rv32i_alu_pkg::tag_t'(slot_q[i].r1)])
				begin
					slot_q[i].r1 <= table_data[rv32i_alu_pkg::tag_t'(slot_q[i].r1)];
					slot_q[i].busy_r1 <= 1'b0;
				end
				if (slot_q[i].busy_r2 && table_valid[rv32i_alu_pkg::tag_t'(slot_q[i].r2)])
				begin
					slot_q[i].r2 <= table_data[rv32i_alu_pkg::tag_t'(slot_q[i].r2)];
					slot_q[i].busy_r2 <= 1'b0;
				end
			end
		end
	end

	// view for execute
	always_comb
	begin
		for (int i = 0; i < `RS_SIZE; i++)
		begin
			entries[i] = slot_q[i];
			entries[i].valid = valid_q[i];
			// both operands resolved
			ready[i] = valid_q[i] && !slot_q[i].busy_r1 && !slot_q[i].busy_r2;
		end
	end

endmodule

// ==== source/issue_decode.sv ====
`timescale 1ns/1ps

module issue_decode
(
	input rv32i_alu_pkg::pci_t pci,
	input rv32i_alu_pkg::src_t src,
	output rv32i_alu_pkg::rs_entry_t new_entry
);

	// arithmetic funct3 values that go to the comparator
	localparam rv32i_alu_pkg::funct3_t f3_slt = 3'b010;
	localparam rv32i_alu_pkg::funct3_t f3_sltu = 3'b011;
	localparam rv32i_alu_pkg::funct3_t f3_sr = 3'b101;
	localparam rv32i_alu_pkg::funct3_t f3_add = 3'b000;

	// alternate encoding bit only for sra, and for sub on register ops
	function automatic rv32i_alu_pkg::alu_ops_e arith_op(
		input rv32i_alu_pkg::funct3_t f3,
		input logic f7_b5,
		input logic is_reg
	);
		logic alt;
		alt = f7_b5 && ((f3 == f3_sr) || (is_reg && (f3 == f3_add)));
		return rv32i_alu_pkg::alu_ops_e'({alt, f3});
	endfunction

	always_comb
	begin
		// defaults, tag filled in by the station
		new_entry = '0;
		new_entry.valid = 1'b1;
		new_entry.alu_op = rv32i_alu_pkg::alu_add;
		new_entry.cmp_op = rv32i_alu_pkg::cmp_beq;
		new_entry.acu_op = 1'b0;

		case (pci.opcode)
			rv32i_alu_pkg::op_jal:
			begin
				// jump target
				new_entry.r1 = pci.pc;
				new_entry.r2 = pci.j_imm;
			end
			rv32i_alu_pkg::op_jalr:
			begin
				new_entry.r1 = src.r1;
				new_entry.busy_r1 = src.busy_r1;
				new_entry.r2 = pci.i_imm;
			end
			rv32i_alu_pkg::op_lui:
			begin
				new_entry.r1 = pci.u_imm;
				new_entry.r2 = '0;
			end
			rv32i_alu_pkg::op_auipc:
			begin
				new_entry.r1 = pci.pc;
				new_entry.r2 = pci.u_imm;
			end
			rv32i_alu_pkg::op_br:
			begin
				// taken bit only
				new_entry.r1 = src.r1;
				new_entry.busy_r1 = src.busy_r1;
				new_entry.r2 = src.r2;
				new_entry.busy_r2 = src.busy_r2;
				new_entry.cmp_op = rv32i_alu_pkg::cmp_ops_e'(pci.funct3);
				new_entry.acu_op = 1'b1;
			end
			rv32i_alu_pkg::op_reg, rv32i_alu_pkg::op_imm:
			begin
				new_entry.r1 = src.r1;
				new_entry.busy_r1 = src.busy_r1;
				if (pci.opcode == rv32i_alu_pkg::op_reg)
				begin
					new_entry.r2 = src.r2;
					new_entry.busy_r2 = src.busy_r2;
				end
				else
					new_entry.r2 = pci.i_imm;
				// slt and sltu become less-than compares
				if (pci.funct3 == f3_slt || pci.funct3 == f3_sltu)
				begin
					new_entry.acu_op = 1'b1;
					new_entry.cmp_op = (pci.funct3 == f3_slt) ? rv32i_alu_pkg::cmp_blt :
						rv32i_alu_pkg::cmp_bltu;
				end
				else
					new_entry.alu_op = arith_op(pci.funct3, pci.funct7_b5,
						pci.opcode == rv32i_alu_pkg::op_reg);
			end
			// unknown opcode never enters the station
			default: new_entry.valid = 1'b0;
		endcase
	end

endmodule

// ==== source/rv32i_alu_pkg.sv ====
`include "rv32i_alu_defs.svh"

package rv32i_alu_pkg;

	// data carrying vectors
	typedef logic [`XLEN-1:0] word_t;
	typedef logic [`TAG_W-1:0] tag_t;
	typedef logic [$clog2(`RS_SIZE)-1:0] rs_idx_t;
	// free count spans 0 to RS_SIZE inclusive
	typedef logic [$clog2(`RS_SIZE+1)-1:0] rs_count_t;
	typedef logic [2:0] funct3_t;

	// rv32i major opcodes handled by this cluster
	typedef enum logic [6:0] {
		op_lui   = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal   = 7'b1101111,
		op_jalr  = 7'b1100111,
		op_br    = 7'b1100011,
		op_imm   = 7'b0010011,
		op_reg   = 7'b0110011
	} opcode_e;

	// {funct7 bit 5, funct3}
	typedef enum logic [3:0] {
		alu_add = 4'b0000,
		alu_sll = 4'b0001,
		alu_sra = 4'b1101,
		alu_sub = 4'b1000,
		alu_xor = 4'b0100,
		alu_srl = 4'b0101,
		alu_or  = 4'b0110,
		alu_and = 4'b0111
	} alu_ops_e;

	// branch funct3 encodings
	typedef enum logic [2:0] {
		cmp_beq  = 3'b000,
		cmp_bne  = 3'b001,
		cmp_blt  = 3'b100,
		cmp_bge  = 3'b101,
		cmp_bltu = 3'b110,
		cmp_bgeu = 3'b111
	} cmp_ops_e;

	// issued instruction fields
	typedef struct packed {
		opcode_e opcode;
		funct3_t funct3;
		logic funct7_b5;
		word_t pc;
		word_t i_imm;
		word_t u_imm;
		word_t j_imm;
	} pci_t;

	// register file read, low TAG_W bits hold the producer tag when busy
	typedef struct packed {
		word_t r1;
		logic busy_r1;
		word_t r2;
		logic busy_r2;
	} src_t;

	typedef struct packed {
		logic valid;
		tag_t tag;
		word_t r1;
		logic busy_r1;
		word_t r2;
		logic busy_r2;
		alu_ops_e alu_op;
		cmp_ops_e cmp_op;
		// set selects the comparator
		logic acu_op;
	} rs_entry_t;

	// result broadcast
	typedef struct packed {
		logic valid;
		tag_t tag;
		word_t data;
	} result_t;

endpackage

// ==== source/rv32i_alu_defs.svh ====
`ifndef RV32I_ALU_DEFS_SVH
`define RV32I_ALU_DEFS_SVH

// sizing for the integer execute cluster

// number of reservation station slots
`define RS_SIZE 8

// reorder tag width
// eight tags, one result table slot each
`define TAG_W 3

// operand and result width
`define XLEN 32

`endif
